// File: alu_pkg.sv
// Shared word types, 74181 select codes and sequencer states; imported by every ALU block
`default_nettype none

package alu_pkg;

   // Operand and result widths
   typedef logic [31:0] word_t;
   // Bit 32 is the sign extension from the ninth slice
   typedef logic [32:0] alu_out_t;
   typedef logic [3:0]  nibble_t;

   // 74181 S select, active-high data convention
   typedef logic [3:0]  alu_func_t;

   // Arithmetic mode codes (mode = 0)
   localparam alu_func_t ALU_F_ADD = 4'b1001;
   localparam alu_func_t ALU_F_SUB = 4'b0110;

   // Logic mode codes (mode = 1)
   localparam alu_func_t ALU_F_AND = 4'b1011;
   localparam alu_func_t ALU_F_OR  = 4'b1110;
   localparam alu_func_t ALU_F_XOR = 4'b0110;

   typedef enum logic [1:0] {
      S_IDLE,
      S_OP,
      S_MUL,
      S_DONE
   } seq_state_t;

   localparam int MUL_STEPS = 32;

endpackage

`default_nettype wire

// File: alu_slice_181.sv
// Behavioral 74181 4-bit ALU slice; instantiated per nibble by the datapath
`timescale 1ns/1ps
`default_nettype none

module alu_slice_181
   import alu_pkg::*;
(
   input  alu_func_t i_s,
   input  logic      i_m_mode,
   input  nibble_t   i_a,
   input  nibble_t   i_b,
   input  logic      i_cin_n,
   output nibble_t   o_f,
   output logic      o_x,
   output logic      o_y,
   output logic      o_aeb
);

   // Per-bit terms of the 74181: F = t1 plus t2 in arithmetic mode.
   // t2 always implies t1, so t1 is the propagate and t2 the generate
   nibble_t    t1;
   nibble_t    t2;
   logic [3:0] c;

   assign t1 = i_a | (i_b & {4{i_s[0]}}) | (~i_b & {4{i_s[1]}});
   assign t2 = (i_a & i_b & {4{i_s[3]}}) | (i_a & ~i_b & {4{i_s[2]}});

   // Ripple carry inside the slice
   always_comb begin
      c[0] = ~i_cin_n;
      for (int k = 0; k < 3; k++) begin
         c[k+1] = t2[k] | (t1[k] & c[k]);
      end
   end

   // Logic mode behaves as if every internal carry were set
   assign o_f = t1 ^ t2 ^ ({4{i_m_mode}} | c);

   // Group propagate and generate, active high here (the part drives them low)
   assign o_x = &t1;
   assign o_y = t2[3]
              | (t1[3] & t2[2])
              | (t1[3] & t1[2] & t2[1])
              | (t1[3] & t1[2] & t1[1] & t2[0]);

   // Open-collector A=B, modeled as a plain output
   assign o_aeb = &o_f;

   // Subtract without carry gives all ones exactly on equal operands
   always_comb begin
      if (!i_m_mode && (i_s == ALU_F_SUB) && i_cin_n) begin
         a_sub_aeb: assert final (o_aeb == (i_a == i_b))
            else $error("A=B disagrees with operand equality in subtract");
      end
   end

endmodule

`default_nettype wire

// File: carry_lookahead_182.sv
// Behavioral 74182 lookahead carry generator; joins four 74181 slices into one group
`timescale 1ns/1ps
`default_nettype none

module carry_lookahead_182 (
   input  logic       i_cn,
   input  logic [3:0] i_x,
   input  logic [3:0] i_y,
   output logic       o_cnx,
   output logic       o_cny,
   output logic       o_cnz,
   output logic       o_x,
   output logic       o_y
);

   // Carries into slices 1, 2 and 3 of the group
   assign o_cnx = i_y[0] | (i_x[0] & i_cn);
   assign o_cny = i_y[1]
                | (i_x[1] & i_y[0])
                | (i_x[1] & i_x[0] & i_cn);
   assign o_cnz = i_y[2]
                | (i_x[2] & i_y[1])
                | (i_x[2] & i_x[1] & i_y[0])
                | (i_x[2] & i_x[1] & i_x[0] & i_cn);

   // Group terms for the next lookahead level
   assign o_x = &i_x;
   assign o_y = i_y[3]
              | (i_x[3] & i_y[2])
              | (i_x[3] & i_x[2] & i_y[1])
              | (i_x[3] & i_x[2] & i_x[1] & i_y[0]);

endmodule

`default_nettype wire

// File: alu_datapath.sv
// 32-bit ALU board of nine 74181 slices and three 74182 chips; combinational datapath
`timescale 1ns/1ps
`default_nettype none

module alu_datapath
   import alu_pkg::*;
(
   input  alu_func_t i_func,
   input  logic      i_mode,
   input  logic      i_cin,
   input  word_t     i_a,
   input  word_t     i_m,
   output alu_out_t  o_alu,
   output logic      o_aeqm,
   output logic      o_cout
);

   // Active-high carry into each slice, carry[8] is the carry out of bit 31
   wire  [8:0] carry;
   logic [7:0] slice_x;
   logic [7:0] slice_y;
   logic [7:0] aeqm_bits;
   logic [1:0] group_x;
   logic [1:0] group_y;
   nibble_t    sign_f;

   assign carry[0] = i_cin;

   // ------------------------------------------------------------------------
   // Slices 0..7 take M on port A and the A operand on port B
   // ------------------------------------------------------------------------
   for (genvar g = 0; g < 8; g++) begin : g_slice
      alu_slice_181 u_slice (
         .i_s      (i_func),
         .i_m_mode (i_mode),
         .i_a      (i_m[4*g +: 4]),
         .i_b      (i_a[4*g +: 4]),
         .i_cin_n  (~carry[g]),
         .o_f      (o_alu[4*g +: 4]),
         .o_x      (slice_x[g]),
         .o_y      (slice_y[g]),
         .o_aeb    (aeqm_bits[g])
      );
   end

   // Ninth slice repeats bit 31 to form the sign bit
   alu_slice_181 u_slice_sign (
      .i_s      (i_func),
      .i_m_mode (i_mode),
      .i_a      ({3'b000, i_m[31]}),
      .i_b      ({3'b000, i_a[31]}),
      .i_cin_n  (~carry[8]),
      .o_f      (sign_f),
      .o_x      (),
      .o_y      (),
      .o_aeb    ()
   );

   assign o_alu[32] = sign_f[0];

   // ------------------------------------------------------------------------
   // Lookahead from two first-level chips and one chaining chip
   // ------------------------------------------------------------------------
   carry_lookahead_182 u_cla_lo (
      .i_cn  (carry[0]),
      .i_x   (slice_x[3:0]),
      .i_y   (slice_y[3:0]),
      .o_cnx (carry[1]),
      .o_cny (carry[2]),
      .o_cnz (carry[3]),
      .o_x   (group_x[0]),
      .o_y   (group_y[0])
   );

   carry_lookahead_182 u_cla_hi (
      .i_cn  (carry[4]),
      .i_x   (slice_x[7:4]),
      .i_y   (slice_y[7:4]),
      .o_cnx (carry[5]),
      .o_cny (carry[6]),
      .o_cnz (carry[7]),
      .o_x   (group_x[1]),
      .o_y   (group_y[1])
   );

   // Only two group inputs are in use
   carry_lookahead_182 u_cla_top (
      .i_cn  (carry[0]),
      .i_x   ({2'b00, group_x}),
      .i_y   ({2'b00, group_y}),
      .o_cnx (carry[4]),
      .o_cny (carry[8]),
      .o_cnz (),
      .o_x   (),
      .o_y   ()
   );

   // Carry has no meaning in logic mode
   assign o_cout = carry[8] & ~i_mode;

   assign o_aeqm = &aeqm_bits;

   // Subtract without carry gives an all-ones word exactly on equal operands
   always_comb begin
      if (!i_mode && (i_func == ALU_F_SUB) && !i_cin) begin
         a_sub_aeqm: assert final (o_aeqm == (i_a == i_m))
            else $error("A=M disagrees with operand equality in subtract");
      end
   end

endmodule

`default_nettype wire

// File: mul_step_counter.sv
// Down-counter of remaining multiply steps; loaded at start, flags the final step
`timescale 1ns/1ps
`default_nettype none

module mul_step_counter
   import alu_pkg::*;
#(
   parameter int MUL_STEPS = alu_pkg::MUL_STEPS
) (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_load,
   input  logic i_step,
   output logic o_last
);

   localparam int CNT_W = (MUL_STEPS > 2) ? $clog2(MUL_STEPS) : 1;

   logic [CNT_W-1:0] cnt_q;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt_q <= '0;
      end else if (i_load) begin
         cnt_q <= CNT_W'(MUL_STEPS - 1);
      end else if (i_step) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   assign o_last = (cnt_q == '0);

   // Sequencer must stop stepping once the last step is reached
   a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_step |-> !o_last)
      else $error("step requested with the counter at zero");

endmodule

`default_nettype wire

// File: mul_q_register.sv
// Multiplier and low-product shift register; the current multiplier bit sits in bit 0
`timescale 1ns/1ps
`default_nettype none

module mul_q_register
   import alu_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst_n,
   input  logic  i_load,
   input  word_t i_load_val,
   input  logic  i_shift,
   input  logic  i_shift_in,
   output word_t o_q,
   output logic  o_lsb
);

   localparam int W = $bits(word_t);

   word_t q_q;

   // Each step the sum's low bit enters from the top, so after the
   // last step the register holds the low product word
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         q_q <= '0;
      end else if (i_load) begin
         q_q <= i_load_val;
      end else if (i_shift) begin
         q_q <= {i_shift_in, q_q[W-1:1]};
      end
   end

   assign o_q   = q_q;
   assign o_lsb = q_q[0];

endmodule

`default_nettype wire

// File: alu_sequencer.sv
// Control FSM for single ALU operations and shift-and-add multiply; drives ALU controls
`timescale 1ns/1ps
`default_nettype none

module alu_sequencer
   import alu_pkg::*;
#(
   parameter int MUL_STEPS = alu_pkg::MUL_STEPS
) (
   input  logic      i_clk,
   input  logic      i_rst_n,
   input  logic      i_start,
   input  logic      i_mul,
   input  alu_func_t i_func,
   input  logic      i_mode,
   input  logic      i_cin,
   input  logic      i_q_lsb,
   input  logic      i_last,
   output alu_func_t o_func,
   output logic      o_mode,
   output logic      o_cin,
   output logic      o_load,
   output logic      o_step,
   output logic      o_acc_we,
   output logic      o_acc_shift,
   output logic      o_busy,
   output logic      o_done
);

   // Logic mode F = B, which passes the accumulator through
   localparam alu_func_t FUNC_PASS_A = 4'b1010;

   seq_state_t state_q;
   seq_state_t state_d;
   alu_func_t  func_q;
   logic       mode_q;
   logic       cin_q;
   logic       busy_q;
   logic       done_q;

   // A multiply ends with one pass cycle in S_OP that also latches the flags
   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: if (i_start) state_d = i_mul ? S_MUL : S_OP;
         S_MUL:  if (i_last) state_d = S_OP;
         S_OP:   state_d = S_DONE;
         S_DONE: state_d = S_IDLE;
         default: state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= S_IDLE;
         func_q  <= '0;
         mode_q  <= 1'b0;
         cin_q   <= 1'b0;
         busy_q  <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         busy_q  <= (state_d != S_IDLE);
         done_q  <= (state_q == S_DONE);
         if (o_load) begin
            func_q <= i_mul ? FUNC_PASS_A : i_func;
            mode_q <= i_mul | i_mode;
            cin_q  <= i_cin & ~i_mul;
         end
      end
   end

   // Start is only taken in idle, anything else is dropped
   assign o_load = (state_q == S_IDLE) && i_start;

   // Multiply step: add when the multiplier bit is set, else pass
   assign o_func = (state_q == S_MUL) ? (i_q_lsb ? ALU_F_ADD : FUNC_PASS_A) : func_q;
   assign o_mode = (state_q == S_MUL) ? ~i_q_lsb : mode_q;
   assign o_cin  = (state_q == S_MUL) ? 1'b0 : cin_q;

   assign o_step      = (state_q == S_MUL) && !i_last;
   assign o_acc_shift = (state_q == S_MUL);
   assign o_acc_we    = (state_q == S_OP);
   assign o_busy      = busy_q;
   assign o_done      = done_q;

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_done |=> !o_done)
      else $error("done held for more than one cycle");

   a_idle_not_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (state_q == S_IDLE) |-> !o_busy)
      else $error("busy raised while idle");

   // Counter and FSM together give exactly MUL_STEPS multiply cycles
   a_mul_length: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_load && i_mul) |=> (state_q == S_MUL) [*MUL_STEPS] ##1 (state_q == S_OP))
      else $error("multiply did not run for MUL_STEPS cycles");

endmodule

`default_nettype wire

// File: alu_core.sv
// Top of the arithmetic section: sequencer, step counter, Q register, operand regs, ALU
`timescale 1ns/1ps
`default_nettype none

module alu_core
   import alu_pkg::*;
#(
   parameter int MUL_STEPS = alu_pkg::MUL_STEPS
) (
   input  logic      i_clk,
   input  logic      i_rst_n,
   input  logic      i_start,
   input  logic      i_mul,
   input  alu_func_t i_func,
   input  logic      i_mode,
   input  logic      i_cin,
   input  word_t     i_a,
   input  word_t     i_m,
   output alu_out_t  o_result,
   output word_t     o_q,
   output logic      o_aeqm,
   output logic      o_cout,
   output logic      o_busy,
   output logic      o_done
);

   alu_func_t dp_func;
   logic      dp_mode;
   logic      dp_cin;
   alu_out_t  dp_alu;
   logic      dp_aeqm;
   logic      dp_cout;
   logic      load;
   logic      step;
   logic      acc_we;
   logic      acc_shift;
   logic      last;
   logic      q_lsb;
   alu_out_t  acc_q;
   word_t     m_q;
   logic      aeqm_q;
   logic      cout_q;

   alu_sequencer #(
      .MUL_STEPS (MUL_STEPS)
   ) u_sequencer (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_start     (i_start),
      .i_mul       (i_mul),
      .i_func      (i_func),
      .i_mode      (i_mode),
      .i_cin       (i_cin),
      .i_q_lsb     (q_lsb),
      .i_last      (last),
      .o_func      (dp_func),
      .o_mode      (dp_mode),
      .o_cin       (dp_cin),
      .o_load      (load),
      .o_step      (step),
      .o_acc_we    (acc_we),
      .o_acc_shift (acc_shift),
      .o_busy      (o_busy),
      .o_done      (o_done)
   );

   mul_step_counter #(
      .MUL_STEPS (MUL_STEPS)
   ) u_step_counter (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_load  (load),
      .i_step  (step),
      .o_last  (last)
   );

   // Multiplier comes from the A operand
   mul_q_register u_q_register (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_load     (load),
      .i_load_val (i_a),
      .i_shift    (acc_shift),
      .i_shift_in (dp_alu[0]),
      .o_q        (o_q),
      .o_lsb      (q_lsb)
   );

   alu_datapath u_datapath (
      .i_func (dp_func),
      .i_mode (dp_mode),
      .i_cin  (dp_cin),
      .i_a    (acc_q[31:0]),
      .i_m    (m_q),
      .o_alu  (dp_alu),
      .o_aeqm (dp_aeqm),
      .o_cout (dp_cout)
   );

   // ------------------------------------------------------------------------
   // Accumulator and M operand
   // ------------------------------------------------------------------------
   // Multiply starts from a cleared partial product. Each step stores
   // carry and sum shifted right one place
   always_ff @(posedge i_clk) begin
      if (load) begin
         acc_q <= i_mul ? alu_out_t'(0) : alu_out_t'(i_a);
         m_q   <= i_m;
      end else if (acc_we) begin
         acc_q  <= dp_alu;
         aeqm_q <= dp_aeqm;
         cout_q <= dp_cout;
      end else if (acc_shift) begin
         acc_q <= {1'b0, dp_cout, dp_alu[31:1]};
      end
   end

   assign o_result = acc_q;
   assign o_aeqm   = aeqm_q;
   assign o_cout   = cout_q;

endmodule

`default_nettype wire

// File: tb_alu_core.sv
// Directed testbench for the ALU core; single ops, equality, multiply and dropped starts
`timescale 1ns/1ps
`default_nettype none

module tb_alu_core
   import alu_pkg::*;
();

   localparam int CLK_PERIOD = 10;
   localparam int N_ARITH    = 16;
   localparam int N_LOGIC    = 8;
   localparam int N_EQ       = 8;
   localparam int N_MUL      = 8;
   localparam int OP_CYCLES  = 4;
   localparam int MUL_CYCLES = MUL_STEPS + 4;
   // Reset, idle window, single ops, random and corner multiplies, dropped start
   localparam int TEST_CYCLES = 4 + 10
                              + (2 * N_ARITH + 3 * N_LOGIC + 2 * N_EQ) * OP_CYCLES
                              + (N_MUL + 7) * MUL_CYCLES;
   localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

   // Local operation selectors for the reference model
   localparam int OP_ADD = 0;
   localparam int OP_SUB = 1;
   localparam int OP_AND = 2;
   localparam int OP_OR  = 3;
   localparam int OP_XOR = 4;

   logic      clk = 1'b0;
   logic      rst_n;
   logic      start;
   logic      mul;
   alu_func_t func;
   logic      mode;
   logic      cin;
   word_t     a;
   word_t     m;
   alu_out_t  result;
   word_t     q;
   logic      aeqm;
   logic      cout;
   logic      busy;
   logic      done;

   logic [15:0] lfsr_q = 16'd22;

   alu_core #(
      .MUL_STEPS (MUL_STEPS)
   ) u_alu_core (
      .i_clk    (clk),
      .i_rst_n  (rst_n),
      .i_start  (start),
      .i_mul    (mul),
      .i_func   (func),
      .i_mode   (mode),
      .i_cin    (cin),
      .i_a      (a),
      .i_m      (m),
      .o_result (result),
      .o_q      (q),
      .o_aeqm   (aeqm),
      .o_cout   (cout),
      .o_busy   (busy),
      .o_done   (done)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the DUT did not finish the tests within %0d ns", WATCHDOG_NS);
      $display("Testbench failed");
      $fatal(1);
   end

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------
   task automatic report_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_word(output word_t w);
      for (int i = 0; i < 32; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         w[i]   = lfsr_q[0];
      end
   endtask

   function automatic alu_func_t op_func(input int op);
      case (op)
         OP_ADD:  return ALU_F_ADD;
         OP_SUB:  return ALU_F_SUB;
         OP_AND:  return ALU_F_AND;
         OP_OR:   return ALU_F_OR;
         default: return ALU_F_XOR;
      endcase
   endfunction

   function automatic logic op_mode(input int op);
      return (op >= OP_AND);
   endfunction

   // M on the first operand, A on the second, result sign-extended into bit 32
   function automatic alu_out_t ref_result(input int op, input logic c,
                                           input word_t op_a, input word_t op_m);
      word_t w;
      case (op)
         OP_ADD:  return {op_m[31], op_m} + {op_a[31], op_a} + 33'(c);
         OP_SUB:  return {op_m[31], op_m} - {op_a[31], op_a} - 33'd1 + 33'(c);
         OP_AND:  w = op_m & op_a;
         OP_OR:   w = op_m | op_a;
         default: w = op_m ^ op_a;
      endcase
      return {w[31], w};
   endfunction

   // Unsigned carry out of bit 31, subtract adds the inverted A
   function automatic logic ref_cout(input int op, input logic c,
                                     input word_t op_a, input word_t op_m);
      logic [32:0] s;
      if (op == OP_ADD) begin
         s = {1'b0, op_m} + {1'b0, op_a} + 33'(c);
      end else begin
         s = {1'b0, op_m} + {1'b0, ~op_a} + 33'(c);
      end
      return s[32];
   endfunction

   // Start strobe is high for exactly one rising edge
   task automatic launch(input logic mul_op, input alu_func_t f, input logic md,
                         input logic c, input word_t op_a, input word_t op_m);
      @(negedge clk);
      mul   = mul_op;
      func  = f;
      mode  = md;
      cin   = c;
      a     = op_a;
      m     = op_m;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   // Counts falling edges after the start edge until done shows
   task automatic wait_done(output int lat);
      lat = 0;
      while (!done) begin
         assert (busy === 1'b1)
            else report_error("busy low while an operation is running");
         @(negedge clk);
         lat++;
      end
   endtask

   task automatic check_op(input int op, input logic c, input word_t op_a, input word_t op_m);
      alu_out_t exp_res;
      int       lat;
      exp_res = ref_result(op, c, op_a, op_m);
      launch(1'b0, op_func(op), op_mode(op), c, op_a, op_m);
      wait_done(lat);
      assert (lat == 2)
         else report_error($sformatf("done after %0d cycles, expected 2", lat));
      assert (result === exp_res)
         else report_error($sformatf("op %0d a=%h m=%h cin=%b result %h, expected %h",
                                     op, op_a, op_m, c, result, exp_res));
      assert (aeqm === (&exp_res[31:0]))
         else report_error($sformatf("A=M is %b for result %h", aeqm, exp_res));
      if (!op_mode(op)) begin
         assert (cout === ref_cout(op, c, op_a, op_m))
            else report_error($sformatf("op %0d a=%h m=%h carry out %b is wrong",
                                        op, op_a, op_m, cout));
      end
   endtask

   task automatic check_mul(input word_t op_a, input word_t op_m);
      logic [63:0] exp_p;
      int          lat;
      exp_p = {32'd0, op_a} * {32'd0, op_m};
      launch(1'b1, ALU_F_ADD, 1'b0, 1'b0, op_a, op_m);
      wait_done(lat);
      assert (lat == MUL_STEPS + 2)
         else report_error($sformatf("multiply done after %0d cycles", lat));
      assert ({result[31:0], q} === exp_p)
         else report_error($sformatf("%h * %h gave %h, expected %h",
                                     op_a, op_m, {result[31:0], q}, exp_p));
   endtask

   // ------------------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------------------
   task automatic check_reset_idle();
      repeat (10) begin
         @(negedge clk);
         assert (busy === 1'b0 && done === 1'b0)
            else report_error("busy or done high after reset without a start");
      end
   endtask

   task automatic check_arith();
      word_t op_a;
      word_t op_m;
      for (int i = 0; i < N_ARITH; i++) begin
         rand_word(op_a);
         rand_word(op_m);
         check_op(OP_ADD, i[0], op_a, op_m);
         check_op(OP_SUB, i[1], op_a, op_m);
      end
   endtask

   task automatic check_logic();
      word_t op_a;
      word_t op_m;
      for (int i = 0; i < N_LOGIC; i++) begin
         rand_word(op_a);
         rand_word(op_m);
         check_op(OP_AND, 1'b0, op_a, op_m);
         check_op(OP_OR, 1'b1, op_a, op_m);
         check_op(OP_XOR, 1'b0, op_a, op_m);
      end
   endtask

   task automatic check_equality();
      word_t op_a;
      word_t op_m;
      for (int i = 0; i < N_EQ; i++) begin
         rand_word(op_a);
         check_op(OP_SUB, 1'b0, op_a, op_a);
         assert (aeqm === 1'b1)
            else report_error($sformatf("A=M low for equal operands %h", op_a));
         // Differ in a single bit
         op_m = op_a ^ (32'd1 << (i * 4 + 1));
         check_op(OP_SUB, 1'b0, op_a, op_m);
         assert (aeqm === 1'b0)
            else report_error($sformatf("A=M high for %h and %h", op_a, op_m));
      end
   endtask

   task automatic check_multiply();
      word_t op_a;
      word_t op_m;
      check_mul(32'd0, 32'd0);
      check_mul('1, '1);
      check_mul(32'd0, '1);
      check_mul('1, 32'd0);
      check_mul(32'd1, '1);
      for (int i = 0; i < N_MUL; i++) begin
         rand_word(op_a);
         rand_word(op_m);
         check_mul(op_a, op_m);
      end
   endtask

   task automatic check_ignored_start();
      word_t       a1;
      word_t       m1;
      word_t       a2;
      word_t       m2;
      logic [63:0] exp_p;
      int          lat;
      int          n;
      rand_word(a1);
      rand_word(m1);
      rand_word(a2);
      rand_word(m2);
      exp_p = {32'd0, a1} * {32'd0, m1};
      launch(1'b1, ALU_F_ADD, 1'b0, 1'b0, a1, m1);
      n = 0;
      repeat (4) begin
         @(negedge clk);
         n++;
      end
      // Second start with other operands while the multiply runs
      mul   = 1'b0;
      func  = ALU_F_SUB;
      a     = a2;
      m     = m2;
      start = 1'b1;
      @(negedge clk);
      n++;
      start = 1'b0;
      wait_done(lat);
      n += lat;
      assert (n == MUL_STEPS + 2)
         else report_error($sformatf("multiply done after %0d cycles", n));
      assert ({result[31:0], q} === exp_p)
         else report_error($sformatf("product %h, expected %h", {result[31:0], q}, exp_p));
      repeat (MUL_STEPS + 4) begin
         @(negedge clk);
         assert (done === 1'b0 && busy === 1'b0)
            else report_error("dropped start produced a second operation");
      end
      assert ({result[31:0], q} === exp_p)
         else report_error("result changed after the multiply finished");
   endtask

   initial begin
      rst_n = 1'b0;
      start = 1'b0;
      mul   = 1'b0;
      func  = '0;
      mode  = 1'b0;
      cin   = 1'b0;
      a     = '0;
      m     = '0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      check_reset_idle();
      check_arith();
      check_logic();
      check_equality();
      check_multiply();
      check_ignored_start();

      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
alu_pkg.sv
alu_slice_181.sv
carry_lookahead_182.sv
alu_datapath.sv
mul_step_counter.sv
mul_q_register.sv
alu_sequencer.sv
alu_core.sv
tb_alu_core.sv

// File: Bender.yml
package:
  name: alu_core

sources:
  # RTL in compile order
  - alu_pkg.sv
  - alu_slice_181.sv
  - carry_lookahead_182.sv
  - alu_datapath.sv
  - mul_step_counter.sv
  - mul_q_register.sv
  - alu_sequencer.sv
  - alu_core.sv

  # Directed testbench
  - target: simulation
    files:
      - tb_alu_core.sv
